//--- Makefile
# Verilator flow for the matrix sum-transpose project

TB_TOP  = tb_matrix_sum_transpose
RTL_TOP = matrix_sum_transpose

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(RTL_TOP)

obj_dir/V$(TB_TOP): verilog.f design/*.sv design/*.svh tb/*.sv
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TB_TOP) -o V$(TB_TOP)

sim: obj_dir/V$(TB_TOP)
	@out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- design/chunk_fifo.sv
// Chunk FIFO
// Synchronous circular buffer with a valid/ready handshake on both
// sides. Depth and payload type are parameters. A write and a read
// may happen in the same cycle.

`timescale 1ns/1ps

module chunk_fifo
  import mst_pkg::*;
#(
  parameter int  DEPTH = 2,
  parameter type T     = chunk_t
) (
  input  logic clk,
  input  logic rst,

  input  T     in_data,
  input  logic in_valid,
  output logic in_ready,

  output T     out_data,
  output logic out_valid,
  input  logic out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  T mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_write;
  logic do_read;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign do_write = in_valid && in_ready;
  assign do_read  = out_valid && out_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous write and read leaves count alone
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- design/chunk_sum_join.sv
// Chunk sum join
// Synchronizes two chunk streams and adds them element-wise modulo 256.
// The result sits in an output register until the consumer takes it.

`timescale 1ns/1ps

module chunk_sum_join
  import mst_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  // First operand, chunks of A
  input  chunk_t a_data,
  input  logic   a_valid,
  output logic   a_ready,

  // Second operand, chunks of B transposed
  input  chunk_t b_data,
  input  logic   b_valid,
  output logic   b_ready,

  // Element-wise sum
  output chunk_t sum_data,
  output logic   sum_valid,
  input  logic   sum_ready
);

  logic   can_accept;
  logic   take;
  chunk_t sum_next;

  // Output register is empty or being drained this cycle
  assign can_accept = !sum_valid || sum_ready;

  // Each side waits on the other, so both transfer together
  assign a_ready = b_valid && can_accept;
  assign b_ready = a_valid && can_accept;

  assign take = a_valid && b_valid && can_accept;

  // Truncation to the element width gives the modulo wrap
  always_comb begin
    for (int k = 0; k < CHUNK_ELEMS; k++) begin
      sum_next[k] = a_data[k] + b_data[k];
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sum_data <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_valid <= 1'b0;
    end else if (take) begin
      sum_valid <= 1'b1;
    end else if (sum_ready) begin
      sum_valid <= 1'b0;
    end
  end

endmodule

//--- design/matrix_stream_transpose.sv
// Streaming matrix transposer
// Takes a matrix one chunk at a time in row-major grid order and emits
// its transpose in the same order. Chunks are buffered per chunk column,
// then read back column by column with the elements of each chunk swapped.

`timescale 1ns/1ps

`include "mst_config.svh"

module matrix_stream_transpose
  import mst_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  // Chunks of B, row-major over the grid
  input  chunk_t in_data,
  input  logic   in_valid,
  output logic   in_ready,

  // Chunks of B transposed, row-major over the grid
  output chunk_t out_data,
  output logic   out_valid,
  input  logic   out_ready
);

  localparam int        CD       = `MST_COMPUTE_DIM;
  localparam grid_idx_t LAST_IDX = grid_idx_t'(GRID_DIM - 1);

  typedef struct packed {
    grid_idx_t row;
    grid_idx_t col;
  } grid_pos_t;

  // Row-major step over the chunk grid, wrapping at the end of a matrix
  function automatic grid_pos_t next_pos(grid_pos_t pos);
    grid_pos_t nxt;
    nxt = pos;
    if (pos.col == LAST_IDX) begin
      nxt.col = '0;
      if (pos.row == LAST_IDX) begin
        nxt.row = '0;
      end else begin
        nxt.row = pos.row + 1'b1;
      end
    end else begin
      nxt.col = pos.col + 1'b1;
    end
    return nxt;
  endfunction

  grid_pos_t in_pos;
  grid_pos_t out_pos;

  logic [GRID_DIM-1:0] col_in_valid;
  logic [GRID_DIM-1:0] col_in_ready;
  logic [GRID_DIM-1:0] col_out_valid;
  logic [GRID_DIM-1:0] col_out_ready;
  chunk_t              col_out_data [GRID_DIM];

  chunk_t sel_chunk;

  // One FIFO per chunk column of B
  for (genvar g = 0; g < GRID_DIM; g++) begin : g_col
    assign col_in_valid[g]  = in_valid && (in_pos.col == grid_idx_t'(g));
    assign col_out_ready[g] = out_ready && (out_pos.row == grid_idx_t'(g));

    chunk_fifo #(
      .DEPTH (GRID_DIM),
      .T     (chunk_t)
    ) i_col_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_data   (in_data),
      .in_valid  (col_in_valid[g]),
      .in_ready  (col_in_ready[g]),
      .out_data  (col_out_data[g]),
      .out_valid (col_out_valid[g]),
      .out_ready (col_out_ready[g])
    );
  end

  // Input side steered by the chunk column of the incoming chunk
  assign in_ready = col_in_ready[in_pos.col];

  // Output row r of the transpose is column r of B
  assign out_valid = col_out_valid[out_pos.row];
  assign sel_chunk = col_out_data[out_pos.row];

  // Swap element positions inside the chunk
  always_comb begin
    for (int i = 0; i < CD; i++) begin
      for (int j = 0; j < CD; j++) begin
        out_data[i*CD + j] = sel_chunk[j*CD + i];
      end
    end
  end

  // Grid counters, each moving on its own handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      in_pos  <= '0;
      out_pos <= '0;
    end else begin
      if (in_valid && in_ready) begin
        in_pos <= next_pos(in_pos);
      end
      if (out_valid && out_ready) begin
        out_pos <= next_pos(out_pos);
      end
    end
  end

endmodule

//--- design/matrix_sum_transpose.sv
// Matrix sum with transpose, top level
// Computes A + B transposed on two chunk streams. A is delayed in a
// chunk FIFO while B goes through the streaming transposer, and the
// join adds the two element-wise.

`timescale 1ns/1ps

`include "mst_config.svh"

module matrix_sum_transpose
  import mst_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  input  chunk_t a_data,
  input  logic   a_valid,
  output logic   a_ready,

  input  chunk_t b_data,
  input  logic   b_valid,
  output logic   b_ready,

  output chunk_t sum_data,
  output logic   sum_valid,
  input  logic   sum_ready
);

  // A path after the delay FIFO
  chunk_t a_q_data;
  logic   a_q_valid;
  logic   a_q_ready;

  // B transposed
  chunk_t bt_data;
  logic   bt_valid;
  logic   bt_ready;

  chunk_fifo #(
    .DEPTH (`MST_A_FIFO_DEPTH),
    .T     (chunk_t)
  ) i_a_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (a_data),
    .in_valid  (a_valid),
    .in_ready  (a_ready),
    .out_data  (a_q_data),
    .out_valid (a_q_valid),
    .out_ready (a_q_ready)
  );

  matrix_stream_transpose i_transpose (
    .clk       (clk),
    .rst       (rst),
    .in_data   (b_data),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .out_data  (bt_data),
    .out_valid (bt_valid),
    .out_ready (bt_ready)
  );

  chunk_sum_join i_join (
    .clk       (clk),
    .rst       (rst),
    .a_data    (a_q_data),
    .a_valid   (a_q_valid),
    .a_ready   (a_q_ready),
    .b_data    (bt_data),
    .b_valid   (bt_valid),
    .b_ready   (bt_ready),
    .sum_data  (sum_data),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

endmodule

//--- design/mst_config.svh
// Matrix sum-transpose configuration
// Element width plus full matrix and compute chunk sizes.
// The chunk size must divide the matrix size evenly.

`ifndef MST_CONFIG_SVH
`define MST_CONFIG_SVH

// Bits per matrix element
`define MST_DATA_WIDTH 8

// Rows and columns of each full square matrix
`define MST_TOTAL_DIM 4

// Rows and columns of one compute chunk
`define MST_COMPUTE_DIM 2

// A-path delay line, one whole matrix of chunks
`define MST_A_FIFO_DEPTH 4

`endif

//--- design/mst_pkg.sv
// Matrix sum-transpose package
// Element and chunk types, plus the counts derived from the
// matrix and chunk sizes.

`include "mst_config.svh"

package mst_pkg;

  // Elements in one chunk
  localparam int CHUNK_ELEMS = `MST_COMPUTE_DIM * `MST_COMPUTE_DIM;

  // Chunks along one side of the full matrix
  localparam int GRID_DIM = `MST_TOTAL_DIM / `MST_COMPUTE_DIM;

  // Width of a chunk row or column index
  localparam int GRID_CNT_W = (GRID_DIM > 1) ? $clog2(GRID_DIM) : 1;

  // One matrix element
  typedef logic [`MST_DATA_WIDTH-1:0] elem_t;

  // Chunk row i, column j lives at index i*MST_COMPUTE_DIM + j
  typedef elem_t [CHUNK_ELEMS-1:0] chunk_t;

  // Position on the chunk grid
  typedef logic [GRID_CNT_W-1:0] grid_idx_t;

endpackage

//--- tb/tb_matrix_sum_transpose.sv
// Testbench for the matrix sum-transpose top level
// Streams A and B matrices as chunks with random gaps and back-pressure,
// and checks every sum chunk against a reference model of A + B transposed.

`timescale 1ns/1ps

`include "mst_config.svh"

module tb_matrix_sum_transpose
  import mst_pkg::*;
;

  localparam int TD          = `MST_TOTAL_DIM;
  localparam int CD          = `MST_COMPUTE_DIM;
  localparam int CW          = $bits(chunk_t);
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  typedef elem_t [TD*TD-1:0] mat_t;
  typedef logic [CW-1:0] word_t;

  logic   clk;
  logic   rst;
  chunk_t a_data;
  logic   a_valid;
  logic   a_ready;
  chunk_t b_data;
  logic   b_valid;
  logic   b_ready;
  chunk_t sum_data;
  logic   sum_valid;
  logic   sum_ready;

  int     seed;
  bit     stim_gaps;
  bit     ready_gaps;
  bit     hold_pending;
  chunk_t held_data;

  mat_t   a_mats [$];
  mat_t   b_mats [$];
  chunk_t exp_q [$];

  matrix_sum_transpose i_dut (
    .clk       (clk),
    .rst       (rst),
    .a_data    (a_data),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .b_data    (b_data),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .sum_data  (sum_data),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_value(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic abort_run(string what);
    $display("Failure at time %0t: %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // Slice chunk (gr, gc) out of a full matrix
  function automatic chunk_t get_chunk(mat_t m, int gr, int gc);
    chunk_t ch;
    for (int i = 0; i < CD; i++) begin
      for (int j = 0; j < CD; j++) begin
        ch[i*CD + j] = m[(gr*CD + i)*TD + gc*CD + j];
      end
    end
    return ch;
  endfunction

  // Reference model, A + B transposed with 8-bit wrap
  function automatic mat_t ref_sum(mat_t a, mat_t b);
    mat_t s;
    for (int r = 0; r < TD; r++) begin
      for (int c = 0; c < TD; c++) begin
        s[r*TD + c] = a[r*TD + c] + b[c*TD + r];
      end
    end
    return s;
  endfunction

  function automatic mat_t random_matrix(bit near_max);
    mat_t m;
    int   v;
    for (int k = 0; k < TD*TD; k++) begin
      v = $random(seed);
      m[k] = near_max ? {4'hF, v[3:0]} : v[7:0];
    end
    return m;
  endfunction

  // Stimulus for both streams plus the expected sum chunks
  task automatic queue_pair(mat_t a, mat_t b);
    mat_t s;
    s = ref_sum(a, b);
    a_mats.push_back(a);
    b_mats.push_back(b);
    for (int gr = 0; gr < GRID_DIM; gr++) begin
      for (int gc = 0; gc < GRID_DIM; gc++) begin
        exp_q.push_back(get_chunk(s, gr, gc));
      end
    end
  endtask

  task automatic idle_gap();
    int n;
    n = 0;
    if (stim_gaps) begin
      n = $unsigned($random(seed)) % 3;
    end
    repeat (n) @(negedge clk);
  endtask

  // Ready is read at the falling edge, where it is already settled
  task automatic send_a_stream();
    mat_t m;
    int   cycles;
    while (a_mats.size() > 0) begin
      m = a_mats.pop_front();
      for (int gr = 0; gr < GRID_DIM; gr++) begin
        for (int gc = 0; gc < GRID_DIM; gc++) begin
          idle_gap();
          a_data  = get_chunk(m, gr, gc);
          a_valid = 1'b1;
          cycles  = 0;
          while (!a_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("a_ready stayed low on the A input stream");
          end
          @(negedge clk);
          a_valid = 1'b0;
        end
      end
    end
  endtask

  task automatic send_b_stream(bit skew);
    mat_t m;
    int   cycles;
    // Skewed case holds B back until the A FIFO is full
    cycles = 0;
    while (skew && a_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("the A FIFO never filled before B was sent");
    end
    while (b_mats.size() > 0) begin
      m = b_mats.pop_front();
      for (int gr = 0; gr < GRID_DIM; gr++) begin
        for (int gc = 0; gc < GRID_DIM; gc++) begin
          idle_gap();
          b_data  = get_chunk(m, gr, gc);
          b_valid = 1'b1;
          cycles  = 0;
          while (!b_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("b_ready stayed low on the B input stream");
          end
          @(negedge clk);
          b_valid = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) abort_run("the sum stream stopped with chunks still due");
    end
  endtask

  task automatic run_phase(bit skew);
    fork
      send_a_stream();
      send_b_stream(skew);
    join
    wait_drain();
  endtask

  // Back-pressure on the sum stream
  always @(negedge clk) begin
    if (ready_gaps) begin
      sum_ready = ($random(seed) % 4) != 0;
    end else begin
      sum_ready = 1'b1;
    end
  end

  // Scoreboard, sampled on the rising edge
  always @(posedge clk) begin : compare
    chunk_t expected;
    if (!rst) begin
      if (hold_pending) begin
        check_value("sum_valid under back-pressure", word_t'(sum_valid), word_t'(1));
        check_value("sum_data under back-pressure", sum_data, held_data);
      end
      if (sum_valid && sum_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a sum chunk arrived with no expected chunk left");
        end else begin
          expected = exp_q.pop_front();
          check_value("sum_data", sum_data, expected);
        end
      end
      hold_pending <= sum_valid && !sum_ready;
      held_data    <= sum_data;
    end
  end

  initial begin
    mat_t zero_m;
    mat_t asc_m;
    mat_t max_m;
    seed         = 46135;
    rst          = 1'b1;
    a_data       = '0;
    a_valid      = 1'b0;
    b_data       = '0;
    b_valid      = 1'b0;
    sum_ready    = 1'b1;
    stim_gaps    = 1'b0;
    ready_gaps   = 1'b0;
    hold_pending = 1'b0;
    held_data    = '0;

    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("sum_valid after reset", word_t'(sum_valid), word_t'(0));
    check_value("a_ready after reset", word_t'(a_ready), word_t'(1));
    check_value("b_ready after reset", word_t'(b_ready), word_t'(1));

    // Zero A with ascending B gives B transposed
    for (int k = 0; k < TD*TD; k++) begin
      zero_m[k] = '0;
      asc_m[k]  = elem_t'(k);
    end
    queue_pair(zero_m, asc_m);
    run_phase(1'b0);

    // Eight random pairs back to back
    for (int p = 0; p < 8; p++) begin
      queue_pair(random_matrix(1'b0), random_matrix(1'b0));
    end
    run_phase(1'b0);

    // Idle gaps on the inputs and random back-pressure
    stim_gaps  = 1'b1;
    ready_gaps = 1'b1;
    for (int p = 0; p < 6; p++) begin
      queue_pair(random_matrix(1'b0), random_matrix(1'b0));
    end
    run_phase(1'b0);
    stim_gaps  = 1'b0;
    ready_gaps = 1'b0;

    // A runs ahead of B
    for (int p = 0; p < 2; p++) begin
      queue_pair(random_matrix(1'b0), random_matrix(1'b0));
    end
    run_phase(1'b1);

    // Values near the top of the range wrap around
    for (int k = 0; k < TD*TD; k++) begin
      max_m[k] = 8'hFF;
    end
    queue_pair(max_m, max_m);
    queue_pair(random_matrix(1'b1), random_matrix(1'b1));
    queue_pair(random_matrix(1'b1), random_matrix(1'b1));
    run_phase(1'b0);

    // No repeated chunk may follow the last expected one
    repeat (8) begin
      @(negedge clk);
      check_value("sum_valid after the last chunk", word_t'(sum_valid), word_t'(0));
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
design/mst_pkg.sv
design/chunk_fifo.sv
design/matrix_stream_transpose.sv
design/chunk_sum_join.sv
design/matrix_sum_transpose.sv
tb/tb_matrix_sum_transpose.sv
